// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_pet_display -o sim_tb_pet_display \
    && ./obj_dir/sim_tb_pet_display \
    || { echo "Simulation failed." >&2; exit 1; }

// ==== sim.f ====
src/pet_display_pkg.sv
src/frame_sequencer.sv
src/sprite_store.sv
src/status_overlay.sv
src/byte_out_buffer.sv
src/pet_display_top.sv
testbench/tb_pet_display.sv

// ==== src/byte_out_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module byte_out_buffer (
    input  wire logic                           clk,
    input  wire logic                           i_rst_n,
    input  wire pet_display_pkg::display_byte_t i_byte,
    input  wire logic                           i_byte_valid,
    output logic                                o_advance,
    output pet_display_pkg::display_byte_t      o_byte,
    output logic                                o_valid,
    input  wire logic                           i_ready
);
    import pet_display_pkg::*;

    display_byte_t head_q;                  // Entry on the output.
    display_byte_t skid_q;                  // Second entry, taken while the sink stalls.
    logic [1:0]    fill;
    logic [1:0]    fill_next;
    logic          advance_q;
    logic          push;
    logic          pop;

    assign push = i_byte_valid && advance_q;
    assign pop = o_valid && i_ready;
    assign fill_next = fill + {1'b0, push} - {1'b0, pop};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            fill <= 2'd0;
            advance_q <= 1'b1;
        end else begin
            fill <= fill_next;
            advance_q <= (fill_next != 2'd2);   // Pipeline moves only with a free entry.
        end
    end

    // A full buffer holds advance low, so push and fill of two never meet.
    always_ff @(posedge clk) begin
        if (pop) begin
            if (fill == 2'd2) begin
                head_q <= skid_q;
            end else if (push) begin
                head_q <= i_byte;
            end
        end else if (push) begin
            if (fill == 2'd0) begin
                head_q <= i_byte;
            end else begin
                skid_q <= i_byte;
            end
        end
    end

    assign o_valid = (fill != 2'd0);
    assign o_byte = head_q;
    assign o_advance = advance_q;

    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_byte)));

endmodule

`default_nettype wire

// ==== src/frame_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_sequencer #(
    parameter int frame_repeat = 8
) (
    input  wire logic                      clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_enable,
    input  wire logic                      i_advance,
    input  wire pet_display_pkg::pose_e    i_pose,
    input  wire pet_display_pkg::pet_stats_t i_stats,
    output pet_display_pkg::pix_req_t      o_req,
    output logic                           o_req_valid
);
    import pet_display_pkg::*;

    localparam int rep_w = (frame_repeat > 1) ? $clog2(frame_repeat) : 1;

    logic [byte_idx_w-1:0]  byte_cnt;
    logic [rep_w-1:0]       rep_cnt;
    logic [2:0]             anim_idx [anim_count];
    pose_e                  pose_q;                 // Pose of the frame in flight.
    logic [2:0]             ofs_q;                  // Mood or animation index of that frame.

    logic                   sof;
    logic                   issue;
    pose_e                  cur_pose;
    logic [2:0]             new_ofs;
    logic [2:0]             cur_ofs;
    logic [sprite_id_w-1:0] cur_frame;

    // Idle sprite chosen from the statistics; earlier rules win.
    function automatic logic [2:0] idle_mood(input pet_stats_t s);
        if (s.happiness > 8'd90 && s.hunger > 8'd90 && s.sleep > 8'd90) begin
            return 3'd0;
        end else if (s.happiness < 8'd10) begin
            return 3'd2;
        end else if (s.hunger < 8'd10) begin
            return 3'd1;
        end else if (s.sleep < 8'd10) begin
            return 3'd5;
        end else if (s.happiness < 8'd20 || s.hunger < 8'd20 || s.sleep < 8'd20) begin
            return 3'd4;
        end
        return 3'd3;
    endfunction

    assign sof = (byte_cnt == '0);
    assign issue = !sof || i_enable;                // A started frame always runs to its end.

    always_comb begin
        case (i_pose)
            pose_intro:    new_ofs = 3'd0;
            pose_idle:     new_ofs = idle_mood(i_stats);
            pose_sleeping: new_ofs = anim_idx[0];
            pose_eating:   new_ofs = anim_idx[1];
            pose_teaching: new_ofs = anim_idx[2];
            default:       new_ofs = anim_idx[3];
        endcase
    end

    // Byte 0 takes the live inputs; the rest of the frame uses the sampled ones.
    assign cur_pose = sof ? i_pose : pose_q;
    assign cur_ofs = sof ? new_ofs : ofs_q;
    assign cur_frame = pose_base[cur_pose] + sprite_id_w'(cur_ofs);

    // ********************
    // Counters
    // ********************

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            byte_cnt <= '0;
            rep_cnt <= '0;
            pose_q <= pose_intro;
            ofs_q <= '0;
            o_req_valid <= 1'b0;
            for (int k = 0; k < anim_count; k++) begin
                anim_idx[k] <= '0;
            end
        end else if (i_advance) begin
            o_req_valid <= issue;
            if (issue) begin
                byte_cnt <= (byte_cnt == byte_idx_w'(frame_bytes - 1)) ? '0 : byte_cnt + 1'b1;
                if (sof) begin
                    pose_q <= i_pose;
                    ofs_q <= new_ofs;
                    if (rep_cnt == rep_w'(frame_repeat - 1)) begin
                        rep_cnt <= '0;
                        for (int k = 0; k < anim_count; k++) begin
                            if ({1'b0, anim_idx[k]} == pose_len[k + 2] - 4'd1) begin
                                anim_idx[k] <= '0;  // Wrap at the pose length.
                            end else begin
                                anim_idx[k] <= anim_idx[k] + 3'd1;
                            end
                        end
                    end else begin
                        rep_cnt <= rep_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance && issue) begin
            o_req.frame <= cur_frame;
            o_req.index <= byte_cnt;
            o_req.sof <= sof;
            o_req.draw_bars <= (cur_pose != pose_intro) && (cur_pose != pose_dead);
        end
    end

    // Every byte of a frame reads the same sprite frame as its byte 0.
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_req_valid && !o_req.sof) |-> o_req.frame == $past(o_req.frame));

endmodule

`default_nettype wire

// ==== src/pet_display_pkg.sv ====
`default_nettype none

package pet_display_pkg;

    // ********************
    // Display geometry
    // ********************

    localparam int frame_bytes = 1024;        // 128 columns by 8 pages.
    localparam int byte_idx_w = 10;
    localparam int sprite_count = 31;         // Sprite frames over all poses.
    localparam int sprite_id_w = 5;
    localparam int anim_count = 4;            // Sleeping, eating, teaching and dead.

    // ********************
    // Status bars
    // ********************

    // Happiness, hunger and sleep, in that order.
    localparam int bar_base_col [3] = '{8, 18, 28};
    localparam int bar_columns = 5;
    localparam logic [7:0] bar_full = 8'hee;  // Two lit nibbles with a gap.
    localparam logic [7:0] bar_half = 8'he0;

    // ********************
    // Poses and sprite table
    // ********************

    typedef enum logic [2:0] {
        pose_intro    = 3'd0,
        pose_idle     = 3'd1,
        pose_sleeping = 3'd2,
        pose_eating   = 3'd3,
        pose_teaching = 3'd4,
        pose_dead     = 3'd5
    } pose_e;

    // First sprite frame and frame count of each pose, indexed by pose_e.
    localparam logic [sprite_id_w-1:0] pose_base [6] = '{5'd0, 5'd1, 5'd7, 5'd11, 5'd16, 5'd23};
    localparam logic [3:0] pose_len [6] = '{4'd1, 4'd6, 4'd4, 4'd5, 4'd7, 4'd8};

    typedef struct packed {
        logic [7:0] happiness;
        logic [7:0] hunger;
        logic [7:0] sleep;
    } pet_stats_t;

    typedef struct packed {
        logic [sprite_id_w-1:0] frame;
        logic [byte_idx_w-1:0]  addr;
        logic [7:0]             data;
    } sprite_wr_t;

    // Token that walks from the sequencer through the store to the overlay.
    typedef struct packed {
        logic [sprite_id_w-1:0] frame;
        logic [byte_idx_w-1:0]  index;
        logic                   sof;
        logic                   draw_bars;
    } pix_req_t;

    typedef struct packed {
        logic [7:0]            data;
        logic [byte_idx_w-1:0] index;
        logic                  sof;
    } display_byte_t;

endpackage

`default_nettype wire

// ==== src/pet_display_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pet_display_top #(
    parameter int frame_repeat = 8
) (
    input  wire logic                           clk,
    input  wire logic                           i_rst_n,
    input  wire logic                           i_enable,
    input  wire pet_display_pkg::pose_e         i_pose,
    input  wire pet_display_pkg::pet_stats_t    i_stats,
    input  wire logic                           i_sprite_wr_valid,
    input  wire pet_display_pkg::sprite_wr_t    i_sprite_wr,
    output pet_display_pkg::display_byte_t      o_byte,
    output logic                                o_valid,
    input  wire logic                           i_ready
);
    import pet_display_pkg::*;

    logic          advance;             // Shared stall for every stage.
    pix_req_t      seq_req;
    logic          seq_req_valid;
    pix_req_t      store_req;
    logic          store_req_valid;
    logic [7:0]    sprite_byte;
    display_byte_t ovl_byte;
    logic          ovl_byte_valid;

    frame_sequencer #(
        .frame_repeat (frame_repeat)
    ) frame_sequencer_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_enable    (i_enable),
        .i_advance   (advance),
        .i_pose      (i_pose),
        .i_stats     (i_stats),
        .o_req       (seq_req),
        .o_req_valid (seq_req_valid)
    );

    sprite_store sprite_store_inst (
        .clk           (clk),
        .i_wr_valid    (i_sprite_wr_valid),
        .i_wr          (i_sprite_wr),
        .i_advance     (advance),
        .i_req         (seq_req),
        .i_req_valid   (seq_req_valid),
        .o_req         (store_req),
        .o_req_valid   (store_req_valid),
        .o_sprite_byte (sprite_byte)
    );

    status_overlay status_overlay_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_advance     (advance),
        .i_stats       (i_stats),
        .i_req         (store_req),
        .i_req_valid   (store_req_valid),
        .i_sprite_byte (sprite_byte),
        .o_byte        (ovl_byte),
        .o_byte_valid  (ovl_byte_valid)
    );

    byte_out_buffer byte_out_buffer_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_byte       (ovl_byte),
        .i_byte_valid (ovl_byte_valid),
        .o_advance    (advance),
        .o_byte       (o_byte),
        .o_valid      (o_valid),
        .i_ready      (i_ready)
    );

endmodule

`default_nettype wire

// ==== src/sprite_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module sprite_store (
    input  wire logic                        clk,
    input  wire logic                        i_wr_valid,
    input  wire pet_display_pkg::sprite_wr_t i_wr,
    input  wire logic                        i_advance,
    input  wire pet_display_pkg::pix_req_t   i_req,
    input  wire logic                        i_req_valid,
    output pet_display_pkg::pix_req_t        o_req,
    output logic                             o_req_valid,
    output logic [7:0]                       o_sprite_byte
);
    import pet_display_pkg::*;

    localparam int addr_w = sprite_id_w + byte_idx_w;

    // Frame number in the upper bits, byte index in the lower.
    logic [7:0] mem [sprite_count * frame_bytes];

    always_ff @(posedge clk) begin
        if (i_wr_valid) begin
            mem[addr_w'({i_wr.frame, i_wr.addr})] <= i_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance) begin
            o_sprite_byte <= mem[addr_w'({i_req.frame, i_req.index})];  // Read beside the token.
            o_req <= i_req;
            o_req_valid <= i_req_valid;
        end
    end

    assert property (@(posedge clk) i_wr_valid |-> int'(i_wr.frame) < sprite_count);

endmodule

`default_nettype wire

// ==== src/status_overlay.sv ====
`timescale 1ns/10ps
`default_nettype none

module status_overlay (
    input  wire logic                        clk,
    input  wire logic                        i_rst_n,
    input  wire logic                        i_advance,
    input  wire pet_display_pkg::pet_stats_t i_stats,
    input  wire pet_display_pkg::pix_req_t   i_req,
    input  wire logic                        i_req_valid,
    input  wire logic [7:0]                  i_sprite_byte,
    output pet_display_pkg::display_byte_t   o_byte,
    output logic                             o_byte_valid
);
    import pet_display_pkg::*;

    pet_stats_t                stats_q;
    logic [7:0]                bar_stat [3];
    logic [byte_idx_w-4:0]     col;
    logic [2:0]                row;
    logic [7:0]                out_data;

    // Segment s lights fully above 110 - 20s and half above 100 - 20s.
    function automatic logic [7:0] bar_byte(input logic [7:0] v, input logic [2:0] s);
        int level;
        int seg;
        level = int'(v);
        seg = int'(s);
        if (level > 110 - 20 * seg) begin
            return bar_full;
        end else if (level > 100 - 20 * seg) begin
            return bar_half;
        end
        return 8'h00;
    endfunction

    // Byte 0 never falls in a bar, so the copy taken with it serves the whole frame.
    always_ff @(posedge clk) begin
        if (i_advance && i_req_valid && i_req.sof) begin
            stats_q <= i_stats;
        end
    end

    assign bar_stat[0] = stats_q.happiness;
    assign bar_stat[1] = stats_q.hunger;
    assign bar_stat[2] = stats_q.sleep;

    assign col = i_req.index[byte_idx_w-1:3];     // One column is eight consecutive bytes.
    assign row = i_req.index[2:0];

    always_comb begin
        out_data = i_sprite_byte;
        if (i_req.draw_bars && row >= 3'd1 && row <= 3'd5) begin
            for (int b = 0; b < 3; b++) begin
                if (int'(col) >= bar_base_col[b] && int'(col) < bar_base_col[b] + bar_columns) begin
                    out_data = bar_byte(bar_stat[b], row);
                end
            end
        end
    end

    // ********************
    // Output register
    // ********************

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_byte_valid <= 1'b0;
        end else if (i_advance) begin
            o_byte_valid <= i_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance) begin
            o_byte.data <= out_data;
            o_byte.index <= i_req.index;
            o_byte.sof <= i_req.sof;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/pet_display_tests.txt ====
// Columns in hex: pose (0 intro 1 idle 2 sleeping 3 eating 4 teaching 5 dead),
// happiness, hunger, sleep, frame count, percent of cycles with ready low.
00 32 32 32 01 00
01 5f 5f 5f 01 14
01 05 2d 2d 01 00
01 2d 05 2d 01 00
01 2d 2d 05 01 1e
01 0f 55 55 01 00
01 2d 55 5f 01 00
02 00 55 5f 0a 00
03 5f 2d 0f 0b 14
04 55 05 2d 0f 00
05 00 00 00 11 0a
01 55 2d 0f 02 46
03 0f 05 55 02 46

// ==== testbench/tb_pet_display.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_pet_display;
    import pet_display_pkg::*;

    localparam int repeat_frames = 2;
    localparam int max_records = 32;
    localparam int bytes_per_frame = 1024;
    localparam int sprite_bytes = 31 * bytes_per_frame;
    localparam int first_frame [6] = '{0, 1, 7, 11, 16, 23};   // Intro to dead.
    localparam int frames_in_pose [6] = '{1, 6, 4, 5, 7, 8};
    localparam int bar_first_col [3] = '{8, 18, 28};
    localparam int change_idx = 32;              // Ahead of the first bar byte at 65.

    logic          clk;
    logic          i_rst_n;
    logic          i_enable;
    pose_e         i_pose;
    pet_stats_t    i_stats;
    logic          i_sprite_wr_valid;
    sprite_wr_t    i_sprite_wr;
    display_byte_t o_byte;
    logic          o_valid;
    logic          i_ready;

    logic [7:0] sprite_model [sprite_bytes];
    logic [7:0] test_mem [6 * max_records];      // Six bytes per record.
    int         record_count = 0;
    int         total_bytes = 0;
    int         received = 0;
    int         frames_seen = 0;                 // Frames started since reset.
    int         watch_limit = 0;

    pet_display_top #(
        .frame_repeat (repeat_frames)
    ) pet_display_top_inst (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_enable          (i_enable),
        .i_pose            (i_pose),
        .i_stats           (i_stats),
        .i_sprite_wr_valid (i_sprite_wr_valid),
        .i_sprite_wr       (i_sprite_wr),
        .o_byte            (o_byte),
        .o_valid           (o_valid),
        .i_ready           (i_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        wait (watch_limit != 0);
        repeat (watch_limit) @(posedge clk);
        $display("Test FAILED");
        $fatal(1, "Timeout: the stream did not finish within %0d cycles.", watch_limit);
    end

    // ********************
    // Reference model
    // ********************

    function automatic int mood_of(input int h, input int u, input int z);
        if (h > 90 && u > 90 && z > 90) return 0;
        if (h < 10) return 2;
        if (u < 10) return 1;
        if (z < 10) return 5;
        if (h < 20 || u < 20 || z < 20) return 4;
        return 3;
    endfunction

    function automatic logic [7:0] bar_level(input int v, input int seg);
        if (v > 110 - 20 * seg) return 8'hee;
        if (v > 100 - 20 * seg) return 8'he0;
        return 8'h00;
    endfunction

    function automatic display_byte_t expected_byte(input int rec, input int frame_no,
                                                    input int idx);
        display_byte_t e;
        int            pose;
        int            st [3];
        int            ofs;
        int            col;
        int            row;
        pose = int'(test_mem[6 * rec]);
        st[0] = int'(test_mem[6 * rec + 1]);
        st[1] = int'(test_mem[6 * rec + 2]);
        st[2] = int'(test_mem[6 * rec + 3]);
        if (pose == 0) begin
            ofs = 0;
        end else if (pose == 1) begin
            ofs = mood_of(st[0], st[1], st[2]);
        end else begin
            ofs = (frame_no / repeat_frames) % frames_in_pose[pose];
        end
        e.data = sprite_model[(first_frame[pose] + ofs) * bytes_per_frame + idx];
        col = idx / 8;
        row = idx % 8;
        // Intro and dead show the bare sprite.
        if (pose != 0 && pose != 5 && row >= 1 && row <= 5) begin
            for (int b = 0; b < 3; b++) begin
                if (col >= bar_first_col[b] && col < bar_first_col[b] + 5) begin
                    e.data = bar_level(st[b], row);
                end
            end
        end
        e.index = byte_idx_w'(idx);
        e.sof = (idx == 0);
        return e;
    endfunction

    task automatic check_data(input display_byte_t got, input display_byte_t exp);
        if (got.data !== exp.data) begin
            $display("[FAIL] %0t ns o_byte.data got %02h expected %02h at index %0d",
                     $time, got.data, exp.data, exp.index);
            $display("Test FAILED");
            $fatal(1, "Display byte data mismatch.");
        end
    endtask

    task automatic check_position(input display_byte_t got, input display_byte_t exp);
        if (got.index !== exp.index || got.sof !== exp.sof) begin
            $display("[FAIL] %0t ns o_byte.index/sof got %0d/%0b expected %0d/%0b",
                     $time, got.index, got.sof, exp.index, exp.sof);
            $display("Test FAILED");
            $fatal(1, "Display byte order mismatch.");
        end
    endtask

    // ********************
    // Stimulus
    // ********************

    task automatic load_sprites();
        logic [7:0] value;
        for (int a = 0; a < sprite_bytes; a++) begin
            value = 8'($urandom);
            sprite_model[a] = value;
            @(negedge clk);
            i_sprite_wr_valid = 1'b1;
            i_sprite_wr.frame = sprite_id_w'(a / bytes_per_frame);
            i_sprite_wr.addr = byte_idx_w'(a % bytes_per_frame);
            i_sprite_wr.data = value;
        end
        @(negedge clk);
        i_sprite_wr_valid = 1'b0;
    endtask

    task automatic apply_record(input int rec);
        i_pose = pose_e'(test_mem[6 * rec][2:0]);
        i_stats = {test_mem[6 * rec + 1], test_mem[6 * rec + 2], test_mem[6 * rec + 3]};
    endtask

    // The byte seen here moves on the next rising edge.
    task automatic take_byte(input int low_pct, output display_byte_t b);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            i_ready = (int'($urandom % 100) >= low_pct);
            if (o_valid && i_ready) begin
                b = o_byte;
                done = 1'b1;
            end
        end
        received++;
    endtask

    task automatic run_record(input int rec);
        display_byte_t got;
        display_byte_t exp;
        int            frames;
        int            low_pct;
        frames = int'(test_mem[6 * rec + 4]);
        low_pct = int'(test_mem[6 * rec + 5]);
        @(negedge clk);
        i_ready = 1'b0;                          // No transfer goes unseen on this edge.
        if (rec == 0) begin
            apply_record(0);
        end
        i_enable = 1'b1;
        for (int f = 0; f < frames; f++) begin
            for (int idx = 0; idx < bytes_per_frame; idx++) begin
                take_byte(low_pct, got);
                exp = expected_byte(rec, frames_seen, idx);
                check_position(got, exp);
                check_data(got, exp);
                // The next record's pose and stats arrive before this frame draws its bars.
                if (f == frames - 1 && idx == change_idx) begin
                    i_enable = 1'b0;
                    if (rec + 1 < record_count) begin
                        apply_record(rec + 1);
                    end
                end
            end
            frames_seen++;
        end
    endtask

    initial begin
        int extra;
        void'($urandom(32'ha6da_bc5a));
        i_rst_n = 1'b0;
        i_enable = 1'b0;
        i_pose = pose_intro;
        i_stats = '0;
        i_sprite_wr_valid = 1'b0;
        i_sprite_wr = '0;
        i_ready = 1'b0;
        for (int k = 0; k < 6 * max_records; k++) begin
            test_mem[k] = 8'hff;                 // Marks the end of the records.
        end
        $readmemh("testbench/pet_display_tests.txt", test_mem);
        while (record_count < max_records && test_mem[6 * record_count] != 8'hff) begin
            total_bytes += int'(test_mem[6 * record_count + 4]) * bytes_per_frame;
            record_count++;
        end
        watch_limit = 4 * total_bytes + sprite_bytes + 200;
        repeat (5) @(negedge clk);
        i_rst_n = 1'b1;
        load_sprites();
        for (int r = 0; r < record_count; r++) begin
            run_record(r);
        end
        extra = 0;
        repeat (16) begin
            @(negedge clk);
            i_ready = 1'b1;
            if (o_valid) begin
                extra++;
            end
        end
        if (record_count > 0 && received == total_bytes && extra == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "Read %0d records, got %0d of %0d bytes and %0d bytes past the end.",
                   record_count, received, total_bytes, extra);
        end
    end

endmodule

`default_nettype wire
